// File: sim.f
hw/clk_regmap_pkg.sv
hw/clk_synth_pkg.sv
hw/clk_cfg_regs.sv
hw/frac_synth.sv
hw/post_divider.sv
hw/lock_detect.sv
hw/clk_and_control.sv
test/tb_clk_and_control.sv

// File: Makefile
# Verilator build and run of the clock control testbench

TOP = tb_clk_and_control

all: run

compile:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: test/tb_clk_and_control.sv
//**************************************************************************
// testbench for the clock control top with config, synth, divider and lock tests
//**************************************************************************
`timescale 1ns/1ps

module tb_clk_and_control
  import clk_regmap_pkg::*;
  import clk_synth_pkg::*;
();

  logic              clk;
  logic              RSTB;
  logic              ref_tick = 1'b0;
  logic              cfg_req;
  logic              cfg_web;
  logic [addr_w-1:0] cfg_ad;
  logic [data_w-1:0] cfg_d;
  logic [data_w-1:0] cfg_q;
  logic              cfg_ack;
  logic              lock;
  logic              out0_tick;
  logic              out1_tick;

  int   cycle;           // rising edges since time 0
  int   errors;
  int   checks;
  int   out0_cnt;
  int   out1_cnt;
  int   ref_cnt;         // ref strobes driven so far
  int   lock_rises;
  int   access_edge;     // edge that took the last cfg access
  logic lock_q = 1'b0;
  bit   ref_on;          // gates the random ref driver

  clk_and_control dut (
    .clk, .RSTB, .ref_tick, .cfg_req, .cfg_web, .cfg_ad, .cfg_d,
    .cfg_q, .cfg_ack, .lock, .out0_tick, .out1_tick
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  always @(negedge clk) begin
    if (cycle >= 20000) begin  // about twice the full run
      $display("timeout: run still going after %0d cycles", cycle);
      $display("Errors found");
      $finish;
    end
  end

  // random reference strobes on roughly one edge in four
  always @(posedge clk) begin
    if (ref_on && $urandom_range(3) == 0) begin
      ref_tick <= 1'b1;
      ref_cnt  <= ref_cnt + 1;
    end else begin
      ref_tick <= 1'b0;
    end
  end

  // counts output strobes and lock rises at mid-cycle
  always @(negedge clk) begin
    if (out0_tick) begin
      out0_cnt <= out0_cnt + 1;
    end
    if (out1_tick) begin
      out1_cnt <= out1_cnt + 1;
    end
    if (lock && !lock_q) begin
      lock_rises <= lock_rises + 1;
    end
    lock_q <= lock;
  end

  function automatic logic [data_w-1:0] reset_word(input logic [addr_w-1:0] a);
    case (a)
      reg_ps0:    return rst_ps0;
      reg_ps1:    return rst_ps1;
      reg_mul:    return rst_mul;
      reg_ssc:    return rst_ssc;
      reg_ldet:   return rst_ldet;
      reg_lf:     return rst_lf;
      default:    return rst_spare;  // both spares
    endcase
  endfunction

  // advance on every presc-th edge and count carries out of acc_w bits
  function automatic int expected_synth_ticks(input logic [step_w-1:0] step, input int presc,
                                              input int cycles);
    logic [acc_w:0] acc;
    int             p;
    int             cnt;
    acc = '0;
    cnt = 0;
    p   = (presc == 0) ? 1 : presc;  // prescale 0 acts as 1
    for (int e = 1; e <= cycles; e++) begin
      if (e % p == 0) begin
        acc = {1'b0, acc[acc_w-1:0]} + (acc_w + 1)'(step);
        if (acc[acc_w]) begin
          cnt++;
        end
      end
    end
    return cnt;
  endfunction

  function automatic int expected_div_ticks(input int ticks, input int l1, input int l2);
    return ticks / ((1 << l1) * ((l2 == 0) ? 1 : l2));
  endfunction

  function automatic logic [data_w-1:0] make_ps_word(input bit en, input bit byp, input bit run,
                                                     input int l1, input int l2);
    return (32'(en) << ps_en_bit) | (32'(byp) << ps_byp_bit) | (32'(run) << ps_run_bit)
         | (32'(l2) << ps_l2_lsb) | (32'(l1) << ps_l1_lsb);
  endfunction

  function automatic logic [data_w-1:0] make_mul_word(input int presc, input bit imode,
                                                      input int mi, input int mf);
    return (32'(presc) << mul_presc_lsb) | (32'(imode) << mul_imode_bit)
         | (32'(mf) << mul_frac_lsb) | (32'(mi) << mul_int_lsb);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_cond(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic wait_ack();
    int lat;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!cfg_ack && lat < 8);
    check_cond(lat == 1, "cfg_ack did not arrive one cycle after the request");
    access_edge = cycle;
    @(negedge clk);
    check_cond(!cfg_ack, "cfg_ack stayed high for more than one cycle");
  endtask

  task automatic cfg_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    @(posedge clk);
    cfg_req <= 1'b1;
    cfg_web <= 1'b0;  // write
    cfg_ad  <= a;
    cfg_d   <= d;
    @(posedge clk);   // access taken here
    cfg_req <= 1'b0;
    wait_ack();
  endtask

  task automatic cfg_read(input logic [addr_w-1:0] a, output logic [data_w-1:0] q);
    @(posedge clk);
    cfg_req <= 1'b1;
    cfg_web <= 1'b1;
    cfg_ad  <= a;
    @(posedge clk);
    cfg_req <= 1'b0;
    wait_ack();
    q = cfg_q;  // held until the next read
  endtask

  task automatic wait_lock(input int limit);
    int n;
    n = 0;
    while (!lock && n < limit) begin
      @(negedge clk);
      n++;
    end
    check_cond(lock, "lock did not rise within the expected time");
  endtask

  task automatic print_test_result(input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d failures", name, errors - err_before);
    end
  endtask

  initial begin : stimulus
    logic [data_w-1:0] q;
    logic [data_w-1:0] word;
    logic [data_w-1:0] wdata [8];
    logic [step_w-1:0] step;
    bit                imode;
    int                err0;
    int                presc;
    int                mi;
    int                mf;
    int                l1;
    int                l2;
    int                e0;
    int                e1;
    int                base0;
    int                base1;
    int                base_ref;
    int                base_rises;
    int                drop_cycle;
    int                exp_cnt;
    RSTB    = 1'b0;
    cfg_req = 1'b0;
    cfg_web = 1'b1;
    cfg_ad  = '0;
    cfg_d   = '0;
    void'($urandom(32'h6089));
    repeat (4) @(posedge clk);
    RSTB <= 1'b1;

    err0 = errors;
    ref_on = 1'b1;  // ref strobes reach both dividers, both disabled by reset words
    for (int a = 0; a < 8; a++) begin
      cfg_read(addr_w'(a), q);
      check_value($sformatf("cfg_q at address %0d", a), q, reset_word(addr_w'(a)));
    end
    ref_on = 1'b0;
    repeat (2) @(negedge clk);
    check_value("lock", 32'(lock), 32'h0);
    check_value("out0_tick count", out0_cnt, 0);
    check_value("out1_tick count", out1_cnt, 0);
    print_test_result("reset values", err0);

    err0 = errors;
    for (int a = 0; a < 8; a++) begin
      word = $urandom;
      if (addr_w'(a) == reg_ps0) begin
        word[ps_run_bit] = 1'b0;  // synth stays stopped so lock is held low
      end
      wdata[a] = word;
      cfg_write(addr_w'(a), word);
    end
    for (int a = 0; a < 8; a++) begin
      cfg_read(addr_w'(a), q);
      word = (addr_w'(a) == reg_ldet) ? {1'b0, wdata[a][data_w-2:0]} : wdata[a];
      check_value($sformatf("cfg_q at address %0d", a), q, word);
    end
    cfg_write(reg_ps0, '0);
    cfg_write(reg_ps1, '0);
    print_test_result("register readback", err0);

    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      imode = (i % 2 == 0);  // even passes integer, odd passes fractional
      presc = $urandom_range(7);
      mi    = $urandom_range(2047, 1024);
      mf    = $urandom_range(4095);
      l1    = $urandom_range(3);
      l2    = $urandom_range(5);
      step  = {mul_int_w'(mi), imode ? mul_frac_w'(0) : mul_frac_w'(mf)};
      cfg_write(reg_mul, make_mul_word(presc, imode, mi, mf));
      base0 = out0_cnt;
      cfg_write(reg_ps0, make_ps_word(1'b1, 1'b0, 1'b1, l1, l2));  // out0 and synth on
      e0 = access_edge;
      repeat (2000) @(negedge clk);
      cfg_write(reg_ps0, make_ps_word(1'b1, 1'b0, 1'b0, l1, l2));  // synth off with out0 on
      e1 = access_edge;
      repeat (3) @(negedge clk);
      exp_cnt = expected_div_ticks(expected_synth_ticks(step, presc, e1 - e0), l1, l2);
      check_value($sformatf("out0_tick count, pass %0d", i), out0_cnt - base0, exp_cnt);
      cfg_write(reg_ps0, '0);  // clears partial divider counts
    end
    print_test_result("synth and divider", err0);

    err0 = errors;
    cfg_write(reg_ps1, make_ps_word(1'b1, 1'b1, 1'b0, 0, 0));  // out1 bypassed
    cfg_write(reg_ps0, make_ps_word(1'b0, 1'b0, 1'b1, 1, 2));  // synth on with out0 off
    base0    = out0_cnt;
    base1    = out1_cnt;
    base_ref = ref_cnt;
    ref_on   = 1'b1;
    repeat (1000) @(negedge clk);
    ref_on = 1'b0;
    repeat (3) @(negedge clk);
    check_cond(ref_cnt - base_ref > 0, "no ref_tick strobes were driven in the window");
    check_value("out1_tick count", out1_cnt - base1, ref_cnt - base_ref);
    check_value("out0_tick count while disabled", out0_cnt - base0, 0);
    cfg_write(reg_ps0, '0);
    cfg_write(reg_ps1, '0);
    print_test_result("bypass and disable", err0);

    err0 = errors;
    word = make_mul_word(1, 1'b1, 2047, 0);  // carry about every other edge
    cfg_write(reg_ldet, 32'd6);
    cfg_write(reg_mul, word);
    base_rises = lock_rises;
    cfg_write(reg_ps0, make_ps_word(1'b0, 1'b0, 1'b1, 0, 0));
    wait_lock(200);
    cfg_read(reg_ldet, q);
    check_value("cfg_q at address 4 while locked", q, {1'b1, 31'd6});
    cfg_write(reg_mul, word);  // same setup still restarts the count
    check_cond(!lock, "lock stayed high after a write to register 2");
    drop_cycle = cycle;
    wait_lock(200);
    check_cond(cycle - drop_cycle >= 6, "lock came back before 6 synth ticks could pass");
    @(negedge clk);
    check_value("lock rise count", lock_rises - base_rises, 2);
    print_test_result("lock detect", err0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: hw/clk_and_control.sv
//**************************************************************************
// clock generation control top: config bank, synthesizer, dividers, lock
//**************************************************************************
`timescale 1ns/1ps

module clk_and_control
  import clk_regmap_pkg::*;
  import clk_synth_pkg::*;
(
  input  logic              clk,
  input  logic              RSTB,
  input  logic              ref_tick,   // reference strobe
  input  logic              cfg_req,
  input  logic              cfg_web,
  input  logic [addr_w-1:0] cfg_ad,
  input  logic [data_w-1:0] cfg_d,
  output logic [data_w-1:0] cfg_q,
  output logic              cfg_ack,
  output logic              lock,
  output logic              out0_tick,
  output logic              out1_tick
);

  logic                  synth_run;
  logic [presc_w-1:0]    prescale;
  logic [mul_int_w-1:0]  mul_int;
  logic [mul_frac_w-1:0] mul_frac;
  logic                  integer_mode;
  logic                  ps0_en;
  logic                  ps0_bypass;
  logic [l1_w-1:0]       ps0_l1;
  logic [l2_w-1:0]       ps0_l2;
  logic                  ps1_en;
  logic                  ps1_bypass;
  logic [l1_w-1:0]       ps1_l1;
  logic [l2_w-1:0]       ps1_l2;
  logic [ldet_w-1:0]     ldet_threshold;
  logic                  mul_wr;
  logic                  synth_tick;  // shared by both dividers and lock

  clk_cfg_regs u_cfg_regs (
    .clk, .RSTB, .cfg_req, .cfg_web, .cfg_ad, .cfg_d, .cfg_q, .cfg_ack, .lock,
    .synth_run, .prescale, .mul_int, .mul_frac, .integer_mode,
    .ps0_en, .ps0_bypass, .ps0_l1, .ps0_l2,
    .ps1_en, .ps1_bypass, .ps1_l1, .ps1_l2,
    .ldet_threshold, .mul_wr
  );

  frac_synth u_synth (
    .clk, .RSTB, .synth_run, .prescale, .mul_int, .mul_frac, .integer_mode, .synth_tick
  );

  post_divider div_out0 (
    .clk, .RSTB, .en(ps0_en), .bypass(ps0_bypass), .l1(ps0_l1), .l2(ps0_l2),
    .synth_tick, .ref_tick, .out_tick(out0_tick)
  );

  post_divider div_out1 (
    .clk, .RSTB, .en(ps1_en), .bypass(ps1_bypass), .l1(ps1_l1), .l2(ps1_l2),
    .synth_tick, .ref_tick, .out_tick(out1_tick)
  );

  lock_detect u_lock (
    .clk, .RSTB, .synth_run, .mul_wr, .synth_tick, .ldet_threshold, .lock
  );

endmodule

// File: hw/lock_detect.sv
//**************************************************************************
// lock detector: counts synth ticks after a restart, locks at threshold
//**************************************************************************
`timescale 1ns/1ps

module lock_detect
  import clk_synth_pkg::*;
(
  input  logic              clk,
  input  logic              RSTB,
  input  logic              synth_run,
  input  logic              mul_wr,
  input  logic              synth_tick,
  input  logic [ldet_w-1:0] ldet_threshold,
  output logic              lock
);

  logic [ldet_w-1:0] tick_cnt;
  logic              cnt_full;
  logic              restart;

  assign cnt_full = &tick_cnt;            // saturate, never wraps
  assign restart  = mul_wr | ~synth_run;  // setup change or synth held

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      tick_cnt <= '0;
      lock     <= 1'b0;
    end else if (restart) begin
      tick_cnt <= '0;
      lock     <= 1'b0;
    end else begin
      if (synth_tick && !cnt_full) begin
        tick_cnt <= tick_cnt + 1'b1;
      end
      lock <= lock | (tick_cnt >= ldet_threshold);  // sticky until restart
    end
  end

  // a setup write from the register bank always drops lock
  unlock_after_setup: assert property (
    @(posedge clk) disable iff (!RSTB) mul_wr |=> !lock
  );

endmodule

// File: hw/post_divider.sv
//**************************************************************************
// post-divider: enable, ref bypass, 2^l1 stage then l2 integer stage
//**************************************************************************
`timescale 1ns/1ps

module post_divider
  import clk_synth_pkg::*;
(
  input  logic            clk,
  input  logic            RSTB,
  input  logic            en,
  input  logic            bypass,
  input  logic [l1_w-1:0] l1,
  input  logic [l2_w-1:0] l2,
  input  logic            synth_tick,
  input  logic            ref_tick,
  output logic            out_tick
);

  logic [p2_w-1:0] p2_cnt;
  logic [p2_w-1:0] p2_last;
  logic [l2_w-1:0] l2_cnt;
  logic [l2_w-1:0] l2_last;
  logic            p2_wrap;
  logic            l2_wrap;

  assign p2_last = ~({p2_w{1'b1}} << l1);              // 2^l1 - 1
  assign l2_last = (l2 == '0) ? '0 : l2 - 1'b1;        // l2 of 0 divides by 1
  assign p2_wrap = synth_tick & (p2_cnt >= p2_last);
  assign l2_wrap = p2_wrap & (l2_cnt >= l2_last);      // final counted tick

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      p2_cnt   <= '0;
      l2_cnt   <= '0;
      out_tick <= 1'b0;
    end else if (!en || bypass) begin
      p2_cnt   <= '0;
      l2_cnt   <= '0;
      out_tick <= en & ref_tick;  // bypass: ref one cycle late
    end else begin
      if (synth_tick) begin
        p2_cnt <= p2_wrap ? '0 : p2_cnt + 1'b1;
      end
      if (p2_wrap) begin
        l2_cnt <= l2_wrap ? '0 : l2_cnt + 1'b1;
      end
      out_tick <= l2_wrap;
    end
  end

  // disabled output goes quiet from the next edge
  quiet_when_disabled: assert property (
    @(posedge clk) disable iff (!RSTB) !en |=> !out_tick
  );

endmodule

// File: hw/frac_synth.sv
//**************************************************************************
// fractional-N synthesizer model: prescaler, phase accumulator, tick strobe
//**************************************************************************
`timescale 1ns/1ps

module frac_synth
  import clk_synth_pkg::*;
(
  input  logic                  clk,
  input  logic                  RSTB,
  input  logic                  synth_run,
  input  logic [presc_w-1:0]    prescale,
  input  logic [mul_int_w-1:0]  mul_int,
  input  logic [mul_frac_w-1:0] mul_frac,
  input  logic                  integer_mode,
  output logic                  synth_tick
);

  logic [presc_w-1:0]    presc_cnt;
  logic [presc_w-1:0]    presc_last;
  logic                  advance;
  logic [mul_frac_w-1:0] frac_eff;
  logic [step_w-1:0]     step;
  logic [acc_w-1:0]      acc;
  logic [acc_w:0]        acc_sum;  // extra bit holds the carry

  assign presc_last = (prescale == '0) ? '0 : prescale - 1'b1;  // 0 acts as 1
  assign advance    = (presc_cnt >= presc_last);  // also recovers if prescale shrinks

  assign frac_eff = integer_mode ? '0 : mul_frac;  // integer mode drops fraction
  assign step     = {mul_int, frac_eff};
  assign acc_sum  = {1'b0, acc} + {{(acc_w + 1 - step_w){1'b0}}, step};

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      presc_cnt  <= '0;
      acc        <= '0;
      synth_tick <= 1'b0;
    end else if (!synth_run) begin
      presc_cnt  <= '0;  // held in reset
      acc        <= '0;
      synth_tick <= 1'b0;
    end else if (advance) begin
      presc_cnt  <= '0;
      acc        <= acc_sum[acc_w-1:0];
      synth_tick <= acc_sum[acc_w];  // carry out, one cycle later
    end else begin
      presc_cnt  <= presc_cnt + 1'b1;
      synth_tick <= 1'b0;
    end
  end

  // stopping the synthesizer kills the strobe from the next edge on
  tick_off_when_stopped: assert property (
    @(posedge clk) disable iff (!RSTB) !synth_run |=> !synth_tick
  );

endmodule

// File: hw/clk_cfg_regs.sv
//**************************************************************************
// config register bank: req/ack access port and synthesizer field decode
//**************************************************************************
`timescale 1ns/1ps

module clk_cfg_regs
  import clk_regmap_pkg::*;
  import clk_synth_pkg::*;
(
  input  logic                  clk,
  input  logic                  RSTB,
  input  logic                  cfg_req,
  input  logic                  cfg_web,       // low = write
  input  logic [addr_w-1:0]     cfg_ad,
  input  logic [data_w-1:0]     cfg_d,
  output logic [data_w-1:0]     cfg_q,
  output logic                  cfg_ack,
  input  logic                  lock,
  output logic                  synth_run,
  output logic [presc_w-1:0]    prescale,
  output logic [mul_int_w-1:0]  mul_int,
  output logic [mul_frac_w-1:0] mul_frac,
  output logic                  integer_mode,
  output logic                  ps0_en,
  output logic                  ps0_bypass,
  output logic [l1_w-1:0]       ps0_l1,
  output logic [l2_w-1:0]       ps0_l2,
  output logic                  ps1_en,
  output logic                  ps1_bypass,
  output logic [l1_w-1:0]       ps1_l1,
  output logic [l2_w-1:0]       ps1_l2,
  output logic [ldet_w-1:0]     ldet_threshold,
  output logic                  mul_wr
);

  logic [data_w-1:0] regs [2**addr_w];  // the eight config words
  ldet_word_u        ldet_word;         // reg 4 as written
  ldet_word_u        ldet_rd;           // reg 4 as read back
  logic              wr_en;
  logic              rd_en;

  assign wr_en = cfg_req & ~cfg_web;
  assign rd_en = cfg_req & cfg_web;

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      regs[reg_ps0]    <= rst_ps0;
      regs[reg_ps1]    <= rst_ps1;
      regs[reg_mul]    <= rst_mul;
      regs[reg_ssc]    <= rst_ssc;
      regs[reg_ldet]   <= rst_ldet;
      regs[reg_lf]     <= rst_lf;
      regs[reg_spare0] <= rst_spare;
      regs[reg_spare1] <= rst_spare;
    end else if (wr_en) begin
      regs[cfg_ad] <= cfg_d;  // takes effect at the request edge
    end
  end

  // status view puts the live lock flag on top of the stored bits
  assign ldet_word = regs[reg_ldet];
  always_comb begin
    ldet_rd.stat.lock   = lock;
    ldet_rd.stat.stored = ldet_word.stat.stored;
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (cfg_ad == reg_ldet) begin
        cfg_q <= ldet_rd;
      end else begin
        cfg_q <= regs[cfg_ad];
      end
    end
  end  // holds until next read

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      cfg_ack <= 1'b0;
      mul_wr  <= 1'b0;
    end else begin
      cfg_ack <= cfg_req;                                             // every access, 1 cycle
      mul_wr  <= wr_en & ((cfg_ad == reg_mul) | (cfg_ad == reg_ps0)); // setup touched
    end
  end

  assign synth_run    = regs[reg_ps0][ps_run_bit];
  assign prescale     = regs[reg_mul][mul_presc_lsb +: presc_w];
  assign mul_int      = regs[reg_mul][mul_int_lsb +: mul_int_w];
  assign mul_frac     = regs[reg_mul][mul_frac_lsb +: mul_frac_w];
  assign integer_mode = regs[reg_mul][mul_imode_bit];

  assign ps0_en     = regs[reg_ps0][ps_en_bit];
  assign ps0_bypass = regs[reg_ps0][ps_byp_bit];
  assign ps0_l1     = regs[reg_ps0][ps_l1_lsb +: l1_w];
  assign ps0_l2     = regs[reg_ps0][ps_l2_lsb +: l2_w];
  assign ps1_en     = regs[reg_ps1][ps_en_bit];
  assign ps1_bypass = regs[reg_ps1][ps_byp_bit];
  assign ps1_l1     = regs[reg_ps1][ps_l1_lsb +: l1_w];
  assign ps1_l2     = regs[reg_ps1][ps_l2_lsb +: l2_w];

  assign ldet_threshold = ldet_word.cfg.threshold;

  // an ack always answers a request seen one edge earlier
  ack_follows_req: assert property (
    @(posedge clk) disable iff (!RSTB) cfg_ack |-> $past(cfg_req)
  );

endmodule

// File: hw/clk_synth_pkg.sv
//**************************************************************************
// synthesizer datapath widths: accumulator, dividers, lock counter
//**************************************************************************
package clk_synth_pkg;

  localparam int acc_w      = 24;                     // phase accumulator
  localparam int mul_int_w  = 11;                     // integer part of step
  localparam int mul_frac_w = 12;                     // fraction part of step
  localparam int step_w     = mul_int_w + mul_frac_w; // 23, always below acc_w

  localparam int l2_w = 8;            // integer divider
  localparam int l1_w = 2;            // power-of-two select, 1..8
  localparam int p2_w = 2**l1_w - 1;  // counter width for up to 2^3 ticks

  localparam int ldet_w  = 9;  // lock threshold / tick counter
  localparam int presc_w = 4;  // reference prescaler

endpackage

// File: hw/clk_regmap_pkg.sv
//**************************************************************************
// clock control register map: addresses, field positions, reset words
//**************************************************************************
package clk_regmap_pkg;

  localparam int addr_w = 3;   // 8 config words
  localparam int data_w = 32;

  localparam logic [addr_w-1:0] reg_ps0    = 3'd0;  // out0 post-divider + synth reset
  localparam logic [addr_w-1:0] reg_ps1    = 3'd1;  // out1 post-divider
  localparam logic [addr_w-1:0] reg_mul    = 3'd2;  // multiplier + prescale
  localparam logic [addr_w-1:0] reg_ssc    = 3'd3;  // spread spectrum, storage only
  localparam logic [addr_w-1:0] reg_ldet   = 3'd4;  // lock threshold / lock status
  localparam logic [addr_w-1:0] reg_lf     = 3'd5;  // loop filter, storage only
  localparam logic [addr_w-1:0] reg_spare0 = 3'd6;
  localparam logic [addr_w-1:0] reg_spare1 = 3'd7;

  // ps word layout
  localparam int ps_l1_lsb  = 0;   // bits 1:0
  localparam int ps_run_bit = 2;   // synth reset release, reg 0 only
  localparam int ps_l2_lsb  = 4;   // bits 11:4
  localparam int ps_en_bit  = 18;
  localparam int ps_byp_bit = 19;

  // mul word layout
  localparam int mul_int_lsb   = 4;   // bits 14:4
  localparam int mul_frac_lsb  = 15;  // bits 26:15
  localparam int mul_imode_bit = 27;
  localparam int mul_presc_lsb = 28;  // bits 31:28

  localparam int ldet_thr_msb = 8;  // threshold in 8:0

  localparam logic [data_w-1:0] rst_ps0   = data_w'(1) << ps_byp_bit;  // bypass on only
  localparam logic [data_w-1:0] rst_ps1   = data_w'(1) << ps_byp_bit;
  localparam logic [data_w-1:0] rst_mul   = (data_w'(1) << mul_presc_lsb)
                                          | (data_w'(1) << mul_imode_bit)
                                          | (data_w'(40) << mul_int_lsb);  // 0x1800_0280
  localparam logic [data_w-1:0] rst_ssc   = '0;
  localparam logic [data_w-1:0] rst_ldet  = 32'h0000_0064;
  localparam logic [data_w-1:0] rst_lf    = 32'h0000_0269;
  localparam logic [data_w-1:0] rst_spare = '0;  // regs 6 and 7

  typedef struct packed {
    logic [data_w-1:ldet_thr_msb+1] rsvd;       // stored, no function
    logic [ldet_thr_msb:0]          threshold;
  } ldet_cfg_t;

  typedef struct packed {
    logic                lock;    // live lock flag on read
    logic [data_w-2:0]   stored;  // rest of the written word
  } ldet_stat_t;

  // reg 4 written as config, read back as status
  typedef union packed {
    ldet_cfg_t  cfg;
    ldet_stat_t stat;
  } ldet_word_u;

endpackage
